//--- verilog/vendPkg.sv
package vendPkg;

    localparam int moneyBits = 9;   // wide enough for the 500 cent ceiling
    localparam int numItems  = 9;
    localparam int numCoins  = 6;

    typedef logic [moneyBits-1:0] moneyT;
    typedef logic [15:0] bcdT;      // four BCD digits, digit 0 in the low nibble

    // cents per coin button, bit 0 upward
    localparam moneyT coinValues [0:numCoins-1] = '{
        9'd5,
        9'd10,
        9'd25,
        9'd50,
        9'd100,
        9'd500
    };

    // item A1 first, C3 last; a zero price marks a sold out item
    localparam moneyT defaultPrices [0:numItems-1] = '{
        9'd100, 9'd0,   9'd125,
        9'd175, 9'd225, 9'd250,
        9'd100, 9'd325, 9'd375
    };

    // active low segments, segment a in the lsb
    localparam logic [6:0] segDigits [0:9] = '{
        7'b1000000,
        7'b1111001,
        7'b0100100,
        7'b0110000,
        7'b0011001,
        7'b0010010,
        7'b0000010,
        7'b1111000,
        7'b0000000,
        7'b0010000
    };

    localparam logic [6:0] segMinus = 7'b0111111;   // middle bar only

endpackage

//--- verilog/buttonSync.sv
module buttonSync #(
    parameter type payloadT = logic
) (
    input  logic    A1,
    input  logic    A2,
    input  payloadT buttons,
    output payloadT pressed
);

    payloadT syncMeta;   // first synchronizer stage
    payloadT syncHeld;   // second stage, safe to use
    payloadT heldLast;   // previous held state for edge detect

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            syncMeta <= '0;
            syncHeld <= '0;
            heldLast <= '0;
        end else begin
            syncMeta <= ~buttons;   // buttons are active low
            syncHeld <= syncMeta;
            heldLast <= syncHeld;
        end
    end

    // one pulse per press, on the released to held transition
    assign pressed = syncHeld & ~heldLast;

endmodule

//--- verilog/priceTable.sv
module priceTable import vendPkg::*; #(
    parameter moneyT prices [0:numItems-1] = defaultPrices
) (
    input  moneyT               credit,
    input  logic [numItems-1:0] itemPress,
    output moneyT               itemPrice,
    output logic [numItems-1:0] affordLeds,
    output logic [numItems-1:0] soldOutLeds
);

    genvar i;

    generate
        for (i = 0; i < numItems; i++) begin : gLed
            // a sold out item is never shown as affordable
            assign affordLeds[i]  = (credit >= prices[i]) && (prices[i] != '0);
            assign soldOutLeds[i] = (prices[i] == '0);
        end
    endgenerate

    // walk from the top so the lowest pressed item is the one that sticks
    always_comb begin
        itemPrice = '0;
        for (int k = numItems - 1; k >= 0; k--) begin
            if (itemPress[k]) begin
                itemPrice = prices[k];
            end
        end
    end

endmodule

//--- verilog/vendControl.sv
module vendControl import vendPkg::*; #(
    parameter int maxCredit = 500
) (
    input  logic                A1,
    input  logic                A2,
    input  logic [numCoins-1:0] coinPress,
    input  logic [numItems-1:0] itemPress,
    input  logic                cancelPress,
    input  moneyT               itemPrice,
    input  logic [numItems-1:0] itemAfford,
    output logic [numItems-1:0] dispensedLeds,
    output moneyT               credit,
    output logic                convertStart,
    output moneyT               convertValue,
    output logic                showNegative,
    output logic                showPoint,
    output logic                clearDisplay
);

    moneyT               change;       // change handed back by the last vend
    moneyT               amount;       // credit, price or shortfall to show
    logic                showChange;   // display source is the change register
    moneyT               coinValue;
    logic [moneyBits:0]  coinSum;      // one extra bit so overflow is visible
    logic                coinHit;
    logic                itemHit;
    logic [numItems-1:0] lowestItem;
    logic                pickAfford;
    moneyT               shortfall;

    // lowest coin bit wins inside the bank
    always_comb begin
        coinValue = '0;
        for (int i = numCoins - 1; i >= 0; i--) begin
            if (coinPress[i]) begin
                coinValue = coinValues[i];
            end
        end
    end

    assign coinHit    = |coinPress;
    assign itemHit    = |itemPress;
    assign coinSum    = {1'b0, credit} + {1'b0, coinValue};
    assign lowestItem = itemPress & (~itemPress + 1'b1);   // isolate lowest set bit
    assign pickAfford = |(lowestItem & itemAfford);

    // a sold out item costs nothing, so the whole credit is short
    assign shortfall = (itemPrice == '0) ? credit : itemPrice - credit;

    assign convertValue = showChange ? change : amount;

    // event priority is cancel, then coins, then items
    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            credit        <= '0;
            change        <= '0;
            amount        <= '0;
            showChange    <= 1'b0;
            dispensedLeds <= '0;
            convertStart  <= 1'b0;
            showNegative  <= 1'b0;
            showPoint     <= 1'b0;
            clearDisplay  <= 1'b0;
        end else begin
            convertStart <= 1'b0;
            clearDisplay <= 1'b0;
            if (cancelPress) begin
                credit        <= '0;
                change        <= '0;
                dispensedLeds <= '0;
                showNegative  <= 1'b0;
                showPoint     <= 1'b0;
                clearDisplay  <= 1'b1;
            end else if (coinHit) begin
                if (coinSum <= maxCredit) begin   // otherwise the coin is rejected
                    credit       <= coinSum[moneyBits-1:0];
                    amount       <= coinSum[moneyBits-1:0];
                    showChange   <= 1'b0;
                    showNegative <= 1'b0;
                    showPoint    <= 1'b1;
                    convertStart <= 1'b1;
                end
            end else if (itemHit) begin
                showPoint    <= 1'b1;
                convertStart <= 1'b1;
                if (credit == '0) begin   // price check only
                    amount       <= itemPrice;
                    showChange   <= 1'b0;
                    showNegative <= 1'b0;
                end else if (pickAfford) begin
                    change        <= credit - itemPrice;
                    credit        <= '0;   // one item per payment
                    dispensedLeds <= lowestItem;
                    showChange    <= 1'b1;
                    showNegative  <= 1'b0;
                end else begin
                    amount       <= shortfall;
                    showChange   <= 1'b0;
                    showNegative <= 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/bcdConverter.sv
module bcdConverter import vendPkg::*; (
    input  logic  A1,
    input  logic  A2,
    input  logic  convertStart,
    input  moneyT convertValue,
    input  logic  showNegative,
    input  logic  showPoint,
    output logic  digitsValid,
    output bcdT   digits,
    output logic  negativeOut,
    output logic  pointOut
);

    localparam int countBits = $clog2(moneyBits + 1);
    localparam logic [countBits-1:0] lastCount = countBits'(moneyBits);

    logic                 busy;
    logic [countBits-1:0] bitCount;     // bits shifted so far
    moneyT                shiftReg;     // binary value, msb leaves first
    bcdT                  work;         // partial BCD result
    bcdT                  adjusted;
    logic                 negLatch;     // flags ride along with the value
    logic                 pointLatch;

    function automatic bcdT addThree(bcdT value);
        bcdT result;
        for (int i = 0; i < 4; i++) begin
            if (value[4*i +: 4] >= 4'd5) begin
                result[4*i +: 4] = value[4*i +: 4] + 4'd3;
            end else begin
                result[4*i +: 4] = value[4*i +: 4];
            end
        end
        return result;
    endfunction

    assign adjusted = addThree(work);

    // sequencing, a new start simply restarts the count
    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            busy        <= 1'b0;
            bitCount    <= '0;
            digitsValid <= 1'b0;
        end else begin
            digitsValid <= 1'b0;
            if (convertStart) begin
                busy     <= 1'b1;
                bitCount <= '0;
            end else if (busy) begin
                if (bitCount == lastCount) begin
                    busy        <= 1'b0;
                    digitsValid <= 1'b1;
                end else begin
                    bitCount <= bitCount + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge A1) begin
        if (convertStart) begin
            shiftReg   <= convertValue;
            work       <= '0;
            negLatch   <= showNegative;
            pointLatch <= showPoint;
        end else if (busy) begin
            if (bitCount == lastCount) begin   // all bits in, publish result
                digits      <= work;
                negativeOut <= negLatch;
                pointOut    <= pointLatch;
            end else begin
                work     <= {adjusted[14:0], shiftReg[moneyBits-1]};
                shiftReg <= shiftReg << 1;
            end
        end
    end

endmodule

//--- verilog/displayScanner.sv
module displayScanner import vendPkg::*; #(
    parameter int scanBits = 17
) (
    input  logic       A1,
    input  logic       A2,
    input  logic       digitsValid,
    input  bcdT        digits,
    input  logic       negativeOut,
    input  logic       pointOut,
    input  logic       clearDisplay,
    output logic [3:0] anodes,
    output logic [7:0] segments
);

    bcdT               shown;        // digits currently on the display
    logic              negShown;
    logic              pointShown;
    logic [scanBits+1:0] scanCount;  // free running divider
    logic [1:0]        scanSel;
    logic [3:0]        digitVal;
    logic [6:0]        segPattern;
    logic              pointOn;

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            shown      <= '0;
            negShown   <= 1'b0;
            pointShown <= 1'b0;
        end else if (clearDisplay) begin
            shown      <= '0;
            negShown   <= 1'b0;
            pointShown <= 1'b0;
        end else if (digitsValid) begin
            shown      <= digits;
            negShown   <= negativeOut;
            pointShown <= pointOut;
        end
    end

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            scanCount <= '0;
        end else begin
            scanCount <= scanCount + 1'b1;
        end
    end

    assign scanSel  = scanCount[scanBits+1:scanBits];
    assign digitVal = shown[4*scanSel +: 4];

    // leading digit is always zero for a shortfall, so the minus takes its place
    always_comb begin
        if (negShown && scanSel == 2'd3) begin
            segPattern = segMinus;
        end else begin
            segPattern = segDigits[digitVal];
        end
    end

    assign pointOn  = pointShown && (scanSel == 2'd2);   // dollars and cents split
    assign anodes   = ~(4'b0001 << scanSel);             // active low enable
    assign segments = {segPattern, ~pointOn};

endmodule

//--- verilog/vendingMachine.sv
module vendingMachine import vendPkg::*; #(
    parameter int    maxCredit = 500,
    parameter moneyT prices [0:numItems-1] = defaultPrices,
    parameter int    scanBits  = 17
) (
    input  logic                A1,
    input  logic                A2,
    input  logic [numItems-1:0] itemButtons,
    input  logic [numCoins-1:0] coinButtons,
    input  logic                cancelButton,
    output logic [numItems-1:0] affordLeds,
    output logic [numItems-1:0] soldOutLeds,
    output logic [numItems-1:0] dispensedLeds,
    output logic [3:0]          anodes,
    output logic [7:0]          segments
);

    logic [numItems-1:0] itemPress;
    logic [numCoins-1:0] coinPress;
    logic                cancelPress;
    moneyT               credit;
    moneyT               itemPrice;
    logic                convertStart;
    moneyT               convertValue;
    logic                showNegative;
    logic                showPoint;
    logic                clearDisplay;
    logic                digitsValid;
    bcdT                 digits;
    logic                negativeOut;
    logic                pointOut;

    buttonSync #(.payloadT(logic [numItems-1:0])) itemSync (
        .A1      (A1),
        .A2      (A2),
        .buttons (itemButtons),
        .pressed (itemPress)
    );

    buttonSync #(.payloadT(logic [numCoins-1:0])) coinSync (
        .A1      (A1),
        .A2      (A2),
        .buttons (coinButtons),
        .pressed (coinPress)
    );

    buttonSync #(.payloadT(logic)) cancelSync (
        .A1      (A1),
        .A2      (A2),
        .buttons (cancelButton),
        .pressed (cancelPress)
    );

    priceTable #(.prices(prices)) prices0 (
        .credit      (credit),
        .itemPress   (itemPress),
        .itemPrice   (itemPrice),
        .affordLeds  (affordLeds),
        .soldOutLeds (soldOutLeds)
    );

    vendControl #(.maxCredit(maxCredit)) control0 (
        .A1            (A1),
        .A2            (A2),
        .coinPress     (coinPress),
        .itemPress     (itemPress),
        .cancelPress   (cancelPress),
        .itemPrice     (itemPrice),
        .itemAfford    (affordLeds),   // green LEDs double as the afford flags
        .dispensedLeds (dispensedLeds),
        .credit        (credit),
        .convertStart  (convertStart),
        .convertValue  (convertValue),
        .showNegative  (showNegative),
        .showPoint     (showPoint),
        .clearDisplay  (clearDisplay)
    );

    bcdConverter convert0 (
        .A1           (A1),
        .A2           (A2),
        .convertStart (convertStart),
        .convertValue (convertValue),
        .showNegative (showNegative),
        .showPoint    (showPoint),
        .digitsValid  (digitsValid),
        .digits       (digits),
        .negativeOut  (negativeOut),
        .pointOut     (pointOut)
    );

    displayScanner #(.scanBits(scanBits)) display0 (
        .A1           (A1),
        .A2           (A2),
        .digitsValid  (digitsValid),
        .digits       (digits),
        .negativeOut  (negativeOut),
        .pointOut     (pointOut),
        .clearDisplay (clearDisplay),
        .anodes       (anodes),
        .segments     (segments)
    );

endmodule

//--- tb/vendingMachineTb.sv
module vendingMachineTb import vendPkg::*;;

    logic                A1;
    logic                A2;
    logic [numItems-1:0] itemButtons;
    logic [numCoins-1:0] coinButtons;
    logic                cancelButton;
    logic [numItems-1:0] affordLeds;
    logic [numItems-1:0] soldOutLeds;
    logic [numItems-1:0] dispensedLeds;
    logic [3:0]          anodes;
    logic [7:0]          segments;

    int opQ[$];       // 0 coin, 1 item, 2 cancel
    int idxQ[$];
    int amountQ[$];   // expected shown amount in cents
    int negQ[$];      // 1 when a minus is expected

    int modelCredit;
    int modelAmount;
    int modelNeg;
    int modelPoint;
    logic [numItems-1:0] modelDispensed;

    int checks     = 0;
    int mismatches = 0;
    int failures   = 0;   // anything that is not a wrong value
    int cycleCount = 0;
    int cycleLimit = 200;

    vendingMachine #(.scanBits(1)) dut0 (
        .A1            (A1),
        .A2            (A2),
        .itemButtons   (itemButtons),
        .coinButtons   (coinButtons),
        .cancelButton  (cancelButton),
        .affordLeds    (affordLeds),
        .soldOutLeds   (soldOutLeds),
        .dispensedLeds (dispensedLeds),
        .anodes        (anodes),
        .segments      (segments)
    );

    initial begin
        A1 = 1'b0;
        forever #5 A1 = ~A1;
    end

    always @(posedge A1) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout, run stopped after %0d cycles", cycleCount);
            $display("tests failed");
            $finish;
        end
    end

    function automatic int priceOf(int i);
        case (i)
            0, 6:    return 100;
            1:       return 0;   // sold out
            2:       return 125;
            3:       return 175;
            4:       return 225;
            5:       return 250;
            7:       return 325;
            default: return 375;
        endcase
    endfunction

    function automatic int coinOf(int i);
        case (i)
            0:       return 5;
            1:       return 10;
            2:       return 25;
            3:       return 50;
            4:       return 100;
            default: return 500;
        endcase
    endfunction

    // active low, segment a in bit 0 up to g in bit 6
    function automatic logic [6:0] digitSeg(int d);
        case (d)
            0:       return 7'b1000000;
            1:       return 7'b1111001;
            2:       return 7'b0100100;
            3:       return 7'b0110000;
            4:       return 7'b0011001;
            5:       return 7'b0010010;
            6:       return 7'b0000010;
            7:       return 7'b1111000;
            8:       return 7'b0000000;
            default: return 7'b0010000;
        endcase
    endfunction

    function automatic int activeAnode(logic [3:0] an);
        case (an)
            4'b1110: return 0;
            4'b1101: return 1;
            4'b1011: return 2;
            4'b0111: return 3;
            default: return -1;
        endcase
    endfunction

    task automatic loadPatterns();
        int fd;
        int code;
        int idx;
        int amount;
        int neg;
        logic [8*96-1:0] lineText;
        logic [8*8-1:0]  opText;
        fd = $fopen("tb/vendPatterns.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("cannot open the pattern file tb/vendPatterns.txt");
        end else begin
            while (!$feof(fd)) begin
                lineText = '0;
                opText   = '0;
                code = $fgets(lineText, fd);
                code = $sscanf(lineText, "%s %d %d %d", opText, idx, amount, neg);
                if (code == 4) begin   // comment and blank lines never give four fields
                    if (opText == "coin") opQ.push_back(0);
                    else if (opText == "item") opQ.push_back(1);
                    else if (opText == "cancel") opQ.push_back(2);
                    else begin
                        failures++;
                        $display("unknown operation %0s in the pattern file", opText);
                        opQ.push_back(2);
                    end
                    idxQ.push_back(idx);
                    amountQ.push_back(amount);
                    negQ.push_back(neg);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic stepModel(int op, int idx);
        if (op == 2) begin
            modelCredit    = 0;
            modelDispensed = '0;
            modelAmount    = 0;
            modelNeg       = 0;
            modelPoint     = 0;
        end else if (op == 0) begin
            if (modelCredit + coinOf(idx) <= 500) begin   // over the ceiling shows nothing new
                modelCredit = modelCredit + coinOf(idx);
                modelAmount = modelCredit;
                modelNeg    = 0;
                modelPoint  = 1;
            end
        end else begin
            modelPoint = 1;
            if (modelCredit == 0) begin
                modelAmount = priceOf(idx);
                modelNeg    = 0;
            end else if (priceOf(idx) != 0 && modelCredit >= priceOf(idx)) begin
                modelAmount    = modelCredit - priceOf(idx);
                modelNeg       = 0;
                modelCredit    = 0;
                modelDispensed = 9'd1 << idx;
            end else begin
                modelAmount = (priceOf(idx) == 0) ? modelCredit : priceOf(idx) - modelCredit;
                modelNeg    = 1;
            end
        end
    endtask

    task automatic pressButton(int op, int idx);
        @(negedge A1);
        if (op == 0) coinButtons = ~(6'd1 << idx);
        else if (op == 1) itemButtons = ~(9'd1 << idx);
        else cancelButton = 1'b0;
        repeat (5) @(negedge A1);
        coinButtons  = '1;
        itemButtons  = '1;
        cancelButton = 1'b1;
    endtask

    task automatic checkLeds();
        logic [numItems-1:0] wantAfford;
        for (int i = 0; i < numItems; i++) begin
            wantAfford[i] = (modelCredit >= priceOf(i)) && (priceOf(i) != 0);
        end
        checks++;
        assert (affordLeds == wantAfford && soldOutLeds == 9'b000000010 &&
                dispensedLeds == modelDispensed) else begin
            mismatches++;
            $display("mismatch at %0t: leds afford %b soldout %b dispensed %b, expected %b %b %b",
                     $time, affordLeds, soldOutLeds, dispensedLeds,
                     wantAfford, 9'b000000010, modelDispensed);
        end
    endtask

    task automatic checkDisplay(int amount, int neg, int point);
        logic [3:0] seen;
        logic [7:0] want;
        int sel;
        int d;
        seen = '0;
        repeat (8) begin   // two cycles per anode with scanBits of 1
            @(negedge A1);
            sel = activeAnode(anodes);
            checks++;
            assert (sel >= 0) else begin
                failures++;
                $display("anodes %b at time %0t do not select exactly one digit", anodes, $time);
            end
            if (sel >= 0) begin
                seen[sel] = 1'b1;
                d = amount;
                repeat (sel) d = d / 10;
                want[7:1] = (neg != 0 && sel == 3) ? 7'b0111111 : digitSeg(d % 10);
                want[0]   = ~(point != 0 && sel == 2);
                assert (segments == want) else begin
                    mismatches++;
                    $display("mismatch at %0t: digit %0d shows %b, expected %b",
                             $time, sel, segments, want);
                end
            end
        end
        checks++;
        assert (seen == 4'hf) else begin
            failures++;
            $display("the display did not scan all four digits");
        end
    endtask

    initial begin
        A2           = 1'b1;
        itemButtons  = '1;
        coinButtons  = '1;
        cancelButton = 1'b1;
        stepModel(2, 0);   // reset state equals a cancel
        loadPatterns();
        cycleLimit = 60 * opQ.size() + 200;
        checks++;
        assert (opQ.size() > 0) else begin
            failures++;
            $display("the pattern file holds no patterns");
        end
        repeat (10) @(negedge A1);
        A2 = 1'b0;
        repeat (4) @(negedge A1);
        checkLeds();
        checkDisplay(0, 0, 0);
        for (int n = 0; n < opQ.size(); n++) begin
            stepModel(opQ[n], idxQ[n]);
            pressButton(opQ[n], idxQ[n]);
            repeat (40) @(negedge A1);
            checks++;
            assert (modelAmount == amountQ[n] && modelNeg == negQ[n]) else begin
                mismatches++;
                $display("mismatch at %0t: pattern %0d expects %0d sign %0d, model %0d sign %0d",
                         $time, n, amountQ[n], negQ[n], modelAmount, modelNeg);
            end
            checkLeds();
            checkDisplay(amountQ[n], negQ[n], modelPoint);
        end
        $display("%0d checks, %0d mismatches, %0d other failures", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tb/vendPatterns.txt
# operation  bit index  expected amount in cents  sign (1 shows a minus)
# cancel lines ignore the bit index
item   0  100  0
item   1  0    0
item   8  375  0
coin   0  5    0
coin   1  15   0
coin   2  40   0
item   0  60   1
coin   3  90   0
coin   4  190  0
item   3  15   0
coin   4  100  0
item   1  100  1
cancel 0  0    0
coin   4  100  0
coin   4  200  0
coin   4  300  0
coin   4  400  0
coin   3  450  0
coin   4  450  0
coin   3  500  0
coin   0  500  0
item   8  125  0
item   5  250  0
coin   5  500  0
cancel 0  0    0
coin   2  25   0
item   7  300  1
coin   5  300  1
coin   4  125  0
item   2  0    0
cancel 0  0    0

//--- files.f
verilog/vendPkg.sv
verilog/buttonSync.sv
verilog/priceTable.sv
verilog/vendControl.sv
verilog/bcdConverter.sv
verilog/displayScanner.sv
verilog/vendingMachine.sv
tb/vendingMachineTb.sv

//--- run.sh
#!/bin/sh
# build and run the vending machine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module vendingMachineTb -f files.f -Mdir obj_dir
./obj_dir/VvendingMachineTb | tee sim.log

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
echo "simulation reported a failure, see sim.log"
exit 1
